// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = memoryGameTb
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = run.log
PASSTEXT = SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# The run fails unless the log holds the pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== src/answerTally.sv ====
`default_nettype none

module answerTally (
  input  logic                           Clk1hz,
  input  logic                           rstN,
  input  logic [gamePkg::countWidth-1:0] answerValue,
  input  logic                           answerStrobe,
  input  logic [gamePkg::countWidth-1:0] shownCount,
  levelPhaseIf.observer                  phase,
  output logic [gamePkg::countWidth-1:0] symCountDiff
);
  import gamePkg::*;

  logic [countWidth-1:0] heldAnswer;
  logic [countWidth-1:0] nextAnswer;
  logic                  takeAnswer;

  // Strobes count only inside the answer window
  assign takeAnswer = answerStrobe && phase.answerPeriod;
  assign nextAnswer = takeAnswer ? answerValue : heldAnswer;

  always_ff @(posedge Clk1hz) begin
    if (!rstN) begin
      heldAnswer <= '0;
    end else if (phase.prelimPeriod) begin
      // Silence during the answer phase means an answer of 0
      heldAnswer <= '0;
    end else if (takeAnswer) begin
      heldAnswer <= answerValue;
    end
  end

  // The difference follows every answer-phase edge, so it is final on entry to the
  // post phase and then holds through the decision second
  always_ff @(posedge Clk1hz) begin
    if (!rstN) begin
      symCountDiff <= '0;
    end else if (phase.answerPeriod) begin
      if (shownCount >= nextAnswer) begin
        symCountDiff <= shownCount - nextAnswer;
      end else begin
        symCountDiff <= nextAnswer - shownCount;
      end
    end
  end

  // The sequencer samples the difference at the end of the post phase
  diffStableInPost : assert property (
    @(posedge Clk1hz) disable iff (!rstN)
    phase.postPeriod |=> $stable(symCountDiff)
  ) else $error("symCountDiff changed during the post phase");

endmodule

`default_nettype wire

// ==== src/gamePkg.sv ====
`default_nettype none

package gamePkg;

  // Phase lengths, counted in ticks of the one-second clock
  localparam int prelimSeconds = 3;
  localparam int gameSeconds   = 20;
  localparam int answerSeconds = 3;
  localparam int postSeconds   = 5;

  // The outcome is decided on the second right after the post phase
  localparam int decisionSecond = prelimSeconds + gameSeconds + answerSeconds + postSeconds;

  // A miss smaller than this still advances the level
  localparam int winMargin = 3;

  // Symbol counts, answers and their difference share one width
  localparam int countWidth = 7;

  // Level number and its ceiling
  localparam int levelWidth = 5;
  localparam int maxLevel   = 31;

  // Second counter of the sequencer, wide enough to reach decisionSecond
  localparam int durationWidth = 5;

  // Any nonzero value keeps the LFSR out of its lock-up state
  localparam logic [15:0] lfsrSeed = 16'hACE1;

endpackage

`default_nettype wire

// ==== src/levelControl.sv ====
`default_nettype none

module levelControl (
  input  logic                           Clk1hz,
  input  logic                           rstN,
  input  logic [gamePkg::countWidth-1:0] symCountDiff,
  levelPhaseIf.ctrl                      phase,
  output logic                           loss
);
  import gamePkg::*;

  logic [durationWidth-1:0] durationCnt;
  logic                     inPrelim;
  logic                     inGame;
  logic                     inAnswer;
  logic                     inPost;
  logic                     atDecision;
  logic                     isWin;

  // Each phase window is its own range of the second counter
  assign inPrelim   = durationCnt < durationWidth'(prelimSeconds);
  assign inGame     = (durationCnt >= durationWidth'(prelimSeconds)) &&
                      (durationCnt < durationWidth'(prelimSeconds + gameSeconds));
  assign inAnswer   = (durationCnt >= durationWidth'(prelimSeconds + gameSeconds)) &&
                      (durationCnt < durationWidth'(prelimSeconds + gameSeconds
                                                    + answerSeconds));
  assign inPost     = (durationCnt >= durationWidth'(prelimSeconds + gameSeconds
                                                     + answerSeconds)) &&
                      (durationCnt < durationWidth'(decisionSecond));
  assign atDecision = durationCnt == durationWidth'(decisionSecond);
  assign isWin      = symCountDiff < countWidth'(winMargin);

  always_ff @(posedge Clk1hz) begin
    if (!rstN) begin
      durationCnt         <= '0;
      phase.prelimPeriod  <= 1'b0;
      phase.gamePeriod    <= 1'b0;
      phase.answerPeriod  <= 1'b0;
      phase.postPeriod    <= 1'b0;
      phase.countDownTime <= '0;
      phase.level         <= '0;
      phase.levelChng     <= 1'b0;
      loss                <= 1'b0;
    end else if (!loss) begin
      // Outputs follow the counter value of the cycle just ending
      phase.prelimPeriod  <= inPrelim;
      phase.gamePeriod    <= inGame;
      phase.answerPeriod  <= inAnswer;
      phase.postPeriod    <= inPost;
      phase.countDownTime <= inPrelim ? 3'(prelimSeconds - durationCnt) : 3'd0;
      phase.levelChng     <= 1'b0;

      if (atDecision) begin
        if (isWin) begin
          phase.levelChng <= 1'b1;
          if (phase.level != levelWidth'(maxLevel)) begin
            phase.level <= phase.level + 1'b1;
          end
          // Next countdown begins on the following cycle
          durationCnt <= '0;
        end else begin
          // A lost game freezes everything until reset
          loss <= 1'b1;
        end
      end else begin
        durationCnt <= durationCnt + 1'b1;
      end
    end
  end

  // At most one phase level is high in any cycle
  onePhaseAtMost : assert property (
    @(posedge Clk1hz)
    $onehot0({phase.prelimPeriod, phase.gamePeriod, phase.answerPeriod, phase.postPeriod})
  ) else $error("more than one phase level is active");

  // Level change is a single-cycle pulse
  levelChngPulse : assert property (
    @(posedge Clk1hz) disable iff (!rstN)
    phase.levelChng |=> !phase.levelChng
  ) else $error("levelChng held high for two cycles");

  // Loss is sticky until reset
  lossSticky : assert property (
    @(posedge Clk1hz) disable iff (!rstN)
    loss |=> loss
  ) else $error("loss dropped without reset");

endmodule

`default_nettype wire

// ==== src/levelPhaseIf.sv ====
`default_nettype none

interface levelPhaseIf;
  import gamePkg::*;

  // One-hot phase levels, all low on the decision second
  logic                  prelimPeriod;
  logic                  gamePeriod;
  logic                  answerPeriod;
  logic                  postPeriod;

  // Countdown shown during the prelim phase, 3 down to 1
  logic [2:0]            countDownTime;

  logic [levelWidth-1:0] level;
  // One-cycle pulse on a won decision
  logic                  levelChng;

  modport ctrl (
    output prelimPeriod, gamePeriod, answerPeriod, postPeriod,
    output countDownTime, level, levelChng
  );

  modport observer (
    input prelimPeriod, gamePeriod, answerPeriod, postPeriod,
    input countDownTime, level, levelChng
  );

endinterface

`default_nettype wire

// ==== src/memoryGameTop.sv ====
`default_nettype none

module memoryGameTop (
  input  logic                           Clk1hz,
  input  logic                           rstN,
  input  logic [gamePkg::countWidth-1:0] answerValue,
  input  logic                           answerStrobe,
  output logic                           prelimPeriod,
  output logic                           gamePeriod,
  output logic                           answerPeriod,
  output logic                           postPeriod,
  output logic [2:0]                     countDownTime,
  output logic [gamePkg::levelWidth-1:0] level,
  output logic                           levelChng,
  output logic                           loss,
  output logic                           symbolShown
);
  import gamePkg::*;

  logic [countWidth-1:0] shownCount;
  logic [countWidth-1:0] symCountDiff;

  levelPhaseIf phaseBus ();

  levelControl u_levelControl (
    .Clk1hz       (Clk1hz),
    .rstN         (rstN),
    .symCountDiff (symCountDiff),
    .phase        (phaseBus.ctrl),
    .loss         (loss)
  );

  symbolSource u_symbolSource (
    .Clk1hz      (Clk1hz),
    .rstN        (rstN),
    .phase       (phaseBus.observer),
    .symbolShown (symbolShown),
    .shownCount  (shownCount)
  );

  answerTally u_answerTally (
    .Clk1hz       (Clk1hz),
    .rstN         (rstN),
    .answerValue  (answerValue),
    .answerStrobe (answerStrobe),
    .shownCount   (shownCount),
    .phase        (phaseBus.observer),
    .symCountDiff (symCountDiff)
  );

  // Phase bus fanned out to the pins
  assign prelimPeriod  = phaseBus.prelimPeriod;
  assign gamePeriod    = phaseBus.gamePeriod;
  assign answerPeriod  = phaseBus.answerPeriod;
  assign postPeriod    = phaseBus.postPeriod;
  assign countDownTime = phaseBus.countDownTime;
  assign level         = phaseBus.level;
  assign levelChng     = phaseBus.levelChng;

endmodule

`default_nettype wire

// ==== src/symbolSource.sv ====
`default_nettype none

module symbolSource (
  input  logic                           Clk1hz,
  input  logic                           rstN,
  levelPhaseIf.observer                  phase,
  output logic                           symbolShown,
  output logic [gamePkg::countWidth-1:0] shownCount
);
  import gamePkg::*;

  logic [15:0] lfsr;
  logic [8:0]  flashThreshold;
  logic        lfsrFeedback;

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  assign lfsrFeedback = lfsr[0];

  always_ff @(posedge Clk1hz) begin
    if (!rstN) begin
      lfsr <= lfsrSeed;
    end else begin
      lfsr <= {1'b0, lfsr[15:1]} ^ (lfsrFeedback ? 16'hB400 : 16'h0000);
    end
  end

  // Base chance of 48/256 per second, rising by 8/256 for every level.
  // From level 26 on every game second flashes.
  assign flashThreshold = 9'd48 + {1'b0, phase.level, 3'b000};

  assign symbolShown = phase.gamePeriod && ({1'b0, lfsr[7:0]} < flashThreshold);

  // The count is idle during the countdown, which clears it for the coming game phase
  always_ff @(posedge Clk1hz) begin
    if (!rstN) begin
      shownCount <= '0;
    end else if (phase.prelimPeriod) begin
      shownCount <= '0;
    end else if (symbolShown) begin
      shownCount <= shownCount + 1'b1;
    end
  end

  // A cleared count gains at most one per game second and never passes the game length
  countWithinGame : assert property (
    @(posedge Clk1hz) disable iff (!rstN)
    shownCount <= countWidth'(gameSeconds)
  ) else $error("shownCount exceeds the number of game seconds");

endmodule

`default_nettype wire

// ==== tb.f ====
src/gamePkg.sv
src/levelPhaseIf.sv
src/levelControl.sv
src/symbolSource.sv
src/answerTally.sv
src/memoryGameTop.sv
verification/memoryGameTb.sv

// ==== verification/gameVectors.txt ====
// Columns: answer offset as 8-bit two's complement hex, expected outcome (1 win, 0 loss)
// Losses use positive offsets so that clamping at 0 cannot turn them into wins
00 1
01 1
ff 1
02 1
fe 1
00 1
01 1
03 0
00 1
02 1
ff 1
10 0
fe 1
00 1
01 1
ff 1
00 1
05 0

// ==== verification/memoryGameTb.sv ====
`default_nettype none

module memoryGameTb;
  import gamePkg::*;

  localparam int levelCycles  = decisionSecond + 1;
  localparam int answerStart  = prelimSeconds + gameSeconds;
  localparam int postStart    = answerStart + answerSeconds;
  localparam int maxVectors   = 32;
  localparam int frozenCycles = 6;
  localparam int resetCycles  = 4;

  logic                  Clk1hz;
  logic                  rstN;
  logic [countWidth-1:0] answerValue;
  logic                  answerStrobe;
  logic                  prelimPeriod;
  logic                  gamePeriod;
  logic                  answerPeriod;
  logic                  postPeriod;
  logic [2:0]            countDownTime;
  logic [levelWidth-1:0] level;
  logic                  levelChng;
  logic                  loss;
  logic                  symbolShown;

  // Two entries per level, the answer offset followed by the outcome bit
  logic [7:0] vecMem [0:2*maxVectors-1];
  int         vectorCount;
  int         errorCount;
  int         checkCount;
  int         cycleCount;
  int         cycleLimit;
  int         seed;
  int         expLevel;

  memoryGameTop u_memoryGameTop (
    .Clk1hz        (Clk1hz),
    .rstN          (rstN),
    .answerValue   (answerValue),
    .answerStrobe  (answerStrobe),
    .prelimPeriod  (prelimPeriod),
    .gamePeriod    (gamePeriod),
    .answerPeriod  (answerPeriod),
    .postPeriod    (postPeriod),
    .countDownTime (countDownTime),
    .level         (level),
    .levelChng     (levelChng),
    .loss          (loss),
    .symbolShown   (symbolShown)
  );

  always #4 Clk1hz = !Clk1hz;

  always @(posedge Clk1hz) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, the levels did not finish in time", cycleCount);
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [3:0] phaseBits();
    return {prelimPeriod, gamePeriod, answerPeriod, postPeriod};
  endfunction

  task automatic checkValue(input string testName, input int expected, input int actual);
    checkCount++;
    assert (expected == actual) else begin
      errorCount++;
      $display("Error %s: expected %0d, actual %0d", testName, expected, actual);
    end
  endtask

  // Every control output low, apart from loss and the held level
  task automatic checkIdle(input string testName, input int expLoss);
    checkValue({testName, " phases"}, 0, int'(phaseBits()));
    checkValue({testName, " countDownTime"}, 0, int'(countDownTime));
    checkValue({testName, " levelChng"}, 0, int'(levelChng));
    checkValue({testName, " symbolShown"}, 0, int'(symbolShown));
    checkValue({testName, " loss"}, expLoss, int'(loss));
    checkValue({testName, " level"}, expLevel, int'(level));
  endtask

  task automatic applyReset();
    rstN         = 1'b0;
    answerStrobe = 1'b0;
    answerValue  = '0;
    expLevel     = 0;
    repeat (resetCycles) @(negedge Clk1hz);
    checkIdle("reset", 0);
    rstN = 1'b1;
  endtask

  task automatic playLevel(input int vecIndex, output logic expWin);
    int         offset;
    int         shown;
    int         answerInt;
    int         missBy;
    logic       useDecoy;
    logic [3:0] expPhases;
    string      tag;
    offset    = int'($signed(vecMem[2*vecIndex]));
    useDecoy  = ($random(seed) & 1) == 1;
    shown     = 0;
    answerInt = 0;
    expWin    = 1'b0;
    for (int c = 0; c < levelCycles; c++) begin
      @(negedge Clk1hz);
      tag = $sformatf("vector %0d cycle %0d", vecIndex, c);
      if (c < prelimSeconds) expPhases = 4'b1000;
      else if (c < answerStart) expPhases = 4'b0100;
      else if (c < postStart) expPhases = 4'b0010;
      else if (c < decisionSecond) expPhases = 4'b0001;
      else expPhases = 4'b0000;
      checkValue({tag, " phases"}, int'(expPhases), int'(phaseBits()));
      checkValue({tag, " countDownTime"}, (c < prelimSeconds) ? prelimSeconds - c : 0,
                 int'(countDownTime));
      assert (!symbolShown || gamePeriod) else begin
        errorCount++;
        $display("At %s symbolShown was high outside the game phase", tag);
      end
      if (symbolShown && gamePeriod) shown++;
      if (c == answerStart) begin
        // The player's answer, clamped to the range of the answer port
        answerInt = shown + offset;
        if (answerInt < 0) answerInt = 0;
        if (answerInt > 127) answerInt = 127;
        missBy = (shown > answerInt) ? shown - answerInt : answerInt - shown;
        expWin = missBy < winMargin;
        assert (expWin == vecMem[2*vecIndex+1][0]) else begin
          errorCount++;
          $display("Vector %0d lists an outcome that contradicts the win rule", vecIndex);
        end
      end
      if (c < decisionSecond) begin
        checkValue({tag, " levelChng"}, 0, int'(levelChng));
        checkValue({tag, " loss"}, 0, int'(loss));
        checkValue({tag, " level"}, expLevel, int'(level));
      end else begin
        if (expWin && expLevel < maxLevel) expLevel++;
        checkValue({tag, " levelChng"}, int'(expWin), int'(levelChng));
        checkValue({tag, " loss"}, int'(!expWin), int'(loss));
        checkValue({tag, " level"}, expLevel, int'(level));
      end
      // Stray strobes in the game and post phases, an optional decoy, then the answer
      answerStrobe = (c == prelimSeconds) || (c == answerStart && useDecoy) ||
                     (c == answerStart + 1) || (c == postStart);
      answerValue  = (c == answerStart + 1) ? countWidth'(answerInt)
                                            : countWidth'(answerInt + 64);
    end
  endtask

  initial begin
    logic won;
    Clk1hz       = 1'b0;
    rstN         = 1'b0;
    answerValue  = '0;
    answerStrobe = 1'b0;
    errorCount   = 0;
    checkCount   = 0;
    cycleCount   = 0;
    seed         = 32'ha884_8aad;
    expLevel     = 0;
    for (int i = 0; i < 2 * maxVectors; i++) vecMem[i] = 8'hff;
    $readmemh("verification/gameVectors.txt", vecMem);
    // A line that was read leaves 0 or 1 in its outcome entry
    vectorCount = 0;
    while (vectorCount < maxVectors && vecMem[2*vectorCount+1] <= 8'h01) vectorCount++;
    cycleLimit = (vectorCount + 2) * levelCycles;
    assert (vectorCount > 0) else begin
      errorCount++;
      $display("No vectors could be read from verification/gameVectors.txt");
    end
    applyReset();
    for (int i = 0; i < vectorCount; i++) begin
      playLevel(i, won);
      if (!won) begin
        repeat (frozenCycles) begin
          @(negedge Clk1hz);
          checkIdle("frozen after loss", 1);
        end
        applyReset();
      end
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
